// File: cdec_expander.sv
/*
 * compressed instruction expander
 * routes the low half to the quadrant decoders, full words pass through
 */

`timescale 1ns/10ps

module cdec_expander #(
  parameter int FPU = 1
) (
  input  logic [cdec_pkg::ILEN-1:0] instr_i,
  output logic [cdec_pkg::ILEN-1:0] instr_o,
  output logic                      is_compressed_o,
  output logic                      illegal_o
);

  import cdec_pkg::*;

  c_instr_u        c_instr;
  logic [ILEN-1:0] q0_instr;
  logic [ILEN-1:0] q1_instr;
  logic [ILEN-1:0] q2_instr;
  logic            q0_ill;
  logic            q1_ill;
  logic            q2_ill;

  // upper half of a compressed fetch word is ignored
  assign c_instr = instr_i[CLEN-1:0];

  cdec_quad0 #(
    .FPU(FPU)
  ) u_quad0 (
    .instr_i   (c_instr),
    .instr_o   (q0_instr),
    .illegal_o (q0_ill)
  );

  cdec_quad1 u_quad1 (
    .instr_i   (c_instr),
    .instr_o   (q1_instr),
    .illegal_o (q1_ill)
  );

  cdec_quad2 #(
    .FPU(FPU)
  ) u_quad2 (
    .instr_i   (c_instr),
    .instr_o   (q2_instr),
    .illegal_o (q2_ill)
  );

  ////////////////////////////////////////////////////////////////////////////
  // quadrant select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (instr_i[1:0])
      QUAD0: begin
        instr_o   = q0_instr;
        illegal_o = q0_ill;
      end
      QUAD1: begin
        instr_o   = q1_instr;
        illegal_o = q1_ill;
      end
      QUAD2: begin
        instr_o   = q2_instr;
        illegal_o = q2_ill;
      end
      default: begin
        // 32-bit word, untouched
        instr_o   = instr_i;
        illegal_o = 1'b0;
      end
    endcase
  end

  assign is_compressed_o = (instr_i[1:0] != QUAD_FULL);

  // decoder illegal bits must never reach a full-length word
  always_comb begin
    assert final (!((instr_i[1:0] == QUAD_FULL) && illegal_o))
      else $error("full-length word flagged illegal");
  end

endmodule

// File: cdec_pkg.sv
/*
 * compressed expander package
 * shared widths, RV32 opcodes, register indices and the 16-bit
 * compressed word seen through each of its instruction formats
 */

package cdec_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // full instruction word
  localparam int ILEN = 32;
  // compressed instruction
  localparam int CLEN = 16;

  ////////////////////////////////////////////////////////////////////////////
  // RV32 major opcodes
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_OPIMM    = 7'b0010011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;

  // fixed registers
  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;

  // prepended to a 3-bit field to reach x8..x15
  localparam logic [1:0] RVC_REG_PREFIX = 2'b01;

  localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;

  // low two bits of a fetch word
  localparam logic [1:0] QUAD0     = 2'b00;
  localparam logic [1:0] QUAD1     = 2'b01;
  localparam logic [1:0] QUAD2     = 2'b10;
  localparam logic [1:0] QUAD_FULL = 2'b11;

  ////////////////////////////////////////////////////////////////////////////
  // compressed formats, msb first
  ////////////////////////////////////////////////////////////////////////////

  // register form (jr, jalr, mv, add, ebreak)
  typedef struct packed {
    logic [3:0] funct4;
    logic [4:0] rd_rs1;
    logic [4:0] rs2;
    logic [1:0] quadrant;
  } c_cr_t;

  // immediate form, imm_hi is bit 12
  typedef struct packed {
    logic [2:0] funct3;
    logic       imm_hi;
    logic [4:0] rd_rs1;
    logic [4:0] imm_lo;
    logic [1:0] quadrant;
  } c_ci_t;

  // stack-relative store
  typedef struct packed {
    logic [2:0] funct3;
    logic [5:0] imm;
    logic [4:0] rs2;
    logic [1:0] quadrant;
  } c_css_t;

  // wide immediate (addi4spn)
  typedef struct packed {
    logic [2:0] funct3;
    logic [7:0] imm;
    logic [2:0] rd_p;
    logic [1:0] quadrant;
  } c_ciw_t;

  // load layout, store puts rs2' where rd' sits
  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] imm_hi;
    logic [2:0] rs1_p;
    logic [1:0] imm_lo;
    logic [2:0] rd_p;
    logic [1:0] quadrant;
  } c_cl_t;

  // branch and the shift/andi/alu group
  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] off_hi;
    logic [2:0] rs1_p;
    logic [4:0] off_lo;
    logic [1:0] quadrant;
  } c_cb_t;

  // jump target, scrambled offset bits
  typedef struct packed {
    logic [2:0]  funct3;
    logic [10:0] target;
    logic [1:0]  quadrant;
  } c_cj_t;

  // one compressed word, the view depends on quadrant and funct3
  typedef union packed {
    c_cr_t  cr;
    c_ci_t  ci;
    c_css_t css;
    c_ciw_t ciw;
    c_cl_t  cl;
    c_cb_t  cb;
    c_cj_t  cj;
  } c_instr_u;

endpackage

// File: cdec_quad0.sv
/*
 * quadrant 0 expander
 * addi4spn, word loads and stores, float word loads and stores
 */

`timescale 1ns/10ps

module cdec_quad0 #(
  parameter int FPU = 1
) (
  input  cdec_pkg::c_instr_u            instr_i,
  output logic [cdec_pkg::ILEN-1:0]     instr_o,
  output logic                          illegal_o
);

  import cdec_pkg::*;

  // word offset of lw/sw, uimm[6:2] with two zero bits
  logic [6:0] woff;
  // scaled stack offset of addi4spn, uimm[9:2]
  logic [7:0] spoff;

  // bit 5 is uimm[6], bit 6 is uimm[2]
  assign woff = {instr_i.cl.imm_lo[0], instr_i.cl.imm_hi, instr_i.cl.imm_lo[1], 2'b00};

  // field order in the word is uimm[5:4|9:6|2|3]
  assign spoff = {instr_i.ciw.imm[5:2], instr_i.ciw.imm[7:6],
                  instr_i.ciw.imm[0], instr_i.ciw.imm[1]};

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;

    case (instr_i.cl.funct3)
      3'b000: begin
        // c.addi4spn -> addi rd', sp, uimm
        instr_o = {2'b00, spoff, 2'b00, REG_SP, 3'b000,
                   RVC_REG_PREFIX, instr_i.ciw.rd_p, OPC_OPIMM};
        // zero immediate is reserved, covers the all-zero word
        illegal_o = (instr_i.ciw.imm == 8'd0);
      end
      3'b010, 3'b011: begin
        // c.lw / c.flw -> (f)lw rd', uimm(rs1')
        instr_o = {5'b0, woff, RVC_REG_PREFIX, instr_i.cl.rs1_p, 3'b010,
                   RVC_REG_PREFIX, instr_i.cl.rd_p,
                   instr_i.cl.funct3[0] ? OPC_LOAD_FP : OPC_LOAD};
        if (instr_i.cl.funct3[0] && (FPU == 0)) begin
          illegal_o = 1'b1;
        end
      end
      3'b110, 3'b111: begin
        // c.sw / c.fsw -> (f)sw rs2', uimm(rs1')
        instr_o = {5'b0, woff[6:5], RVC_REG_PREFIX, instr_i.cl.rd_p,
                   RVC_REG_PREFIX, instr_i.cl.rs1_p, 3'b010, woff[4:0],
                   instr_i.cl.funct3[0] ? OPC_STORE_FP : OPC_STORE};
        if (instr_i.cl.funct3[0] && (FPU == 0)) begin
          illegal_o = 1'b1;
        end
      end
      default: begin
        // fld, fsd and the reserved code
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

// File: cdec_quad1.sv
/*
 * quadrant 1 expander
 * immediate arithmetic, lui, shifts, register ALU ops, jumps and branches
 */

`timescale 1ns/10ps

module cdec_quad1 (
  input  cdec_pkg::c_instr_u            instr_i,
  output logic [cdec_pkg::ILEN-1:0]     instr_o,
  output logic                          illegal_o
);

  import cdec_pkg::*;

  // sign extended 6-bit immediate of the ci form
  logic [11:0] simm;
  // addi16sp immediate, nzimm[11:0]
  logic [11:0] sp16;
  // jump offset bits 11..1
  logic [11:1] joff;
  // branch offset bits 8..1
  logic [8:1]  boff;
  // expanded registers x8..x15
  logic [4:0]  rs1_x;
  logic [4:0]  rs2_x;
  // register ALU group select and its function codes
  logic        alu_grp;
  logic [2:0]  alu_f3;
  logic        alu_sub;

  assign simm = {{7{instr_i.ci.imm_hi}}, instr_i.ci.imm_lo};

  // bit 12 is nzimm[9], bits 6:2 are nzimm[4|6|8:7|5]
  assign sp16 = {{3{instr_i.ci.imm_hi}}, instr_i.ci.imm_lo[2:1], instr_i.ci.imm_lo[3],
                 instr_i.ci.imm_lo[0], instr_i.ci.imm_lo[4], 4'b0000};

  // target holds offset[11|4|9:8|10|6|7|3:1|5]
  assign joff = {instr_i.cj.target[10], instr_i.cj.target[6], instr_i.cj.target[8:7],
                 instr_i.cj.target[4], instr_i.cj.target[5], instr_i.cj.target[0],
                 instr_i.cj.target[9], instr_i.cj.target[3:1]};

  // off_hi holds offset[8|4:3], off_lo holds offset[7:6|2:1|5]
  assign boff = {instr_i.cb.off_hi[2], instr_i.cb.off_lo[4:3], instr_i.cb.off_lo[0],
                 instr_i.cb.off_hi[1:0], instr_i.cb.off_lo[2:1]};

  assign rs1_x = {RVC_REG_PREFIX, instr_i.cb.rs1_p};
  assign rs2_x = {RVC_REG_PREFIX, instr_i.cl.rd_p};

  assign alu_grp = (instr_i.cb.funct3 == 3'b100) && (instr_i.cb.off_hi[1:0] == 2'b11);

  // sub, xor, or, and by bits 6:5
  always_comb begin
    alu_sub = 1'b0;
    case (instr_i.cl.imm_lo)
      2'b00: begin
        alu_f3  = 3'b000;
        alu_sub = 1'b1;
      end
      2'b01: alu_f3 = 3'b100;
      2'b10: alu_f3 = 3'b110;
      default: alu_f3 = 3'b111;
    endcase
  end

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;

    case (instr_i.ci.funct3)
      3'b000: begin
        // c.addi, c.nop and hints -> addi rd, rd, imm
        instr_o = {simm, instr_i.ci.rd_rs1, 3'b000, instr_i.ci.rd_rs1, OPC_OPIMM};
      end
      3'b001, 3'b101: begin
        // c.jal links to ra, c.j to x0
        instr_o = {joff[11], joff[10:1], joff[11], {8{joff[11]}},
                   instr_i.cj.funct3[2] ? REG_ZERO : REG_RA, OPC_JAL};
      end
      3'b010: begin
        // c.li -> addi rd, x0, imm
        instr_o = {simm, REG_ZERO, 3'b000, instr_i.ci.rd_rs1, OPC_OPIMM};
      end
      3'b011: begin
        if (instr_i.ci.rd_rs1 == REG_SP) begin
          // c.addi16sp -> addi sp, sp, nzimm
          instr_o = {sp16, REG_SP, 3'b000, REG_SP, OPC_OPIMM};
        end else begin
          // c.lui -> lui rd, nzimm
          instr_o = {{15{instr_i.ci.imm_hi}}, instr_i.ci.imm_lo, instr_i.ci.rd_rs1, OPC_LUI};
        end
        illegal_o = ({instr_i.ci.imm_hi, instr_i.ci.imm_lo} == 6'd0);
      end
      3'b100: begin
        case (instr_i.cb.off_hi[1:0])
          2'b00, 2'b01: begin
            // c.srli / c.srai, bit 10 picks arithmetic
            instr_o = {1'b0, instr_i.cb.off_hi[0], 5'b0, instr_i.cb.off_lo,
                       rs1_x, 3'b101, rs1_x, OPC_OPIMM};
            // shamt[5] does not exist on RV32
            illegal_o = instr_i.cb.off_hi[2];
          end
          2'b10: begin
            // c.andi -> andi rd', rd', imm
            instr_o = {{7{instr_i.cb.off_hi[2]}}, instr_i.cb.off_lo,
                       rs1_x, 3'b111, rs1_x, OPC_OPIMM};
          end
          default: begin
            if (instr_i.cb.off_hi[2]) begin
              // subw, addw and reserved codes
              illegal_o = 1'b1;
            end else begin
              instr_o = {1'b0, alu_sub, 5'b0, rs2_x, rs1_x, alu_f3, rs1_x, OPC_OP};
            end
          end
        endcase
      end
      default: begin
        // c.beqz / c.bnez -> beq/bne rs1', x0, offset
        instr_o = {boff[8], {2{boff[8]}}, boff[8:5], REG_ZERO, rs1_x,
                   2'b00, instr_i.cb.funct3[0], boff[4:1], boff[8], OPC_BRANCH};
      end
    endcase
  end

  // a rejected ALU encoding must not leak a partial instruction downstream
  always_comb begin
    if (alu_grp) begin
      assert final (!(illegal_o && (instr_o != '0)))
        else $error("quad1 ALU group flagged illegal with nonzero expansion");
    end
  end

endmodule

// File: cdec_quad2.sv
/*
 * quadrant 2 expander
 * slli, stack-relative loads and stores, jr/jalr/mv/add/ebreak
 */

`timescale 1ns/10ps

module cdec_quad2 #(
  parameter int FPU = 1
) (
  input  cdec_pkg::c_instr_u            instr_i,
  output logic [cdec_pkg::ILEN-1:0]     instr_o,
  output logic                          illegal_o
);

  import cdec_pkg::*;

  // lwsp offset uimm[7:0], bits 6:2 are uimm[4:2|7:6]
  logic [7:0] loff;
  // swsp offset uimm[7:0], bits 12:7 are uimm[5:2|7:6]
  logic [7:0] soff;
  // rs2 field zero splits jr/jalr from mv/add
  logic       rs2_zero;
  logic       rd_zero;

  assign loff = {instr_i.ci.imm_lo[1:0], instr_i.ci.imm_hi, instr_i.ci.imm_lo[4:2], 2'b00};
  assign soff = {instr_i.css.imm[1:0], instr_i.css.imm[5:2], 2'b00};

  assign rs2_zero = (instr_i.cr.rs2 == REG_ZERO);
  assign rd_zero  = (instr_i.cr.rd_rs1 == REG_ZERO);

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;

    case (instr_i.ci.funct3)
      3'b000: begin
        // c.slli -> slli rd, rd, shamt
        instr_o = {7'b0, instr_i.ci.imm_lo, instr_i.ci.rd_rs1, 3'b001,
                   instr_i.ci.rd_rs1, OPC_OPIMM};
        // shamt[5] is reserved on RV32
        illegal_o = instr_i.ci.imm_hi;
      end
      3'b010: begin
        // c.lwsp -> lw rd, uimm(sp)
        instr_o = {4'b0, loff, REG_SP, 3'b010, instr_i.ci.rd_rs1, OPC_LOAD};
        illegal_o = rd_zero;
      end
      3'b011: begin
        // c.flwsp -> flw rd, uimm(sp), f0 is a valid target
        instr_o = {4'b0, loff, REG_SP, 3'b010, instr_i.ci.rd_rs1, OPC_LOAD_FP};
        illegal_o = (FPU == 0);
      end
      3'b100: begin
        if (!instr_i.cr.funct4[0]) begin
          if (rs2_zero) begin
            // c.jr -> jalr x0, 0(rs1)
            instr_o = {12'b0, instr_i.cr.rd_rs1, 3'b000, REG_ZERO, OPC_JALR};
            illegal_o = rd_zero;
          end else begin
            // c.mv -> add rd, x0, rs2
            instr_o = {7'b0, instr_i.cr.rs2, REG_ZERO, 3'b000, instr_i.cr.rd_rs1, OPC_OP};
          end
        end else begin
          if (rs2_zero && rd_zero) begin
            instr_o = INSTR_EBREAK;
          end else if (rs2_zero) begin
            // c.jalr -> jalr ra, 0(rs1)
            instr_o = {12'b0, instr_i.cr.rd_rs1, 3'b000, REG_RA, OPC_JALR};
          end else begin
            // c.add -> add rd, rd, rs2
            instr_o = {7'b0, instr_i.cr.rs2, instr_i.cr.rd_rs1, 3'b000,
                       instr_i.cr.rd_rs1, OPC_OP};
          end
        end
      end
      3'b110, 3'b111: begin
        // c.swsp / c.fswsp -> (f)sw rs2, uimm(sp)
        instr_o = {4'b0, soff[7:5], instr_i.css.rs2, REG_SP, 3'b010, soff[4:0],
                   instr_i.css.funct3[0] ? OPC_STORE_FP : OPC_STORE};
        if (instr_i.css.funct3[0] && (FPU == 0)) begin
          illegal_o = 1'b1;
        end
      end
      default: begin
        // fldsp and fsdsp
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

// File: cdec_top.sv
/*
 * compressed expander pipeline stage
 * expands the strobed fetch word and registers it for decode
 */

`timescale 1ns/10ps

module cdec_top #(
  parameter int FPU = 1
) (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      valid_i,
  input  logic [cdec_pkg::ILEN-1:0] instr_i,
  output logic                      valid_o,
  output logic [cdec_pkg::ILEN-1:0] instr_o,
  output logic                      is_compressed_o,
  output logic                      illegal_o
);

  import cdec_pkg::*;

  // combinational expansion of the incoming word
  logic [ILEN-1:0] exp_instr;
  logic            exp_comp;
  logic            exp_ill;

  cdec_expander #(
    .FPU(FPU)
  ) u_expander (
    .instr_i         (instr_i),
    .instr_o         (exp_instr),
    .is_compressed_o (exp_comp),
    .illegal_o       (exp_ill)
  );

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o         <= 1'b0;
      instr_o         <= '0;
      is_compressed_o <= 1'b0;
      illegal_o       <= 1'b0;
    end else begin
      valid_o <= valid_i;
      // data holds its last value between strobes
      if (valid_i) begin
        instr_o         <= exp_instr;
        is_compressed_o <= exp_comp;
        illegal_o       <= exp_ill;
      end
    end
  end

  a_valid_known: assert property (@(posedge clk) !$isunknown(valid_o))
    else $error("valid_o unknown");

  // compressed flag tracks the marker of the word sampled one edge earlier
  a_comp_flag: assert property (@(posedge clk) disable iff (!rst_n_i)
    valid_o |-> (is_compressed_o == ($past(instr_i[1:0]) != QUAD_FULL)))
    else $error("is_compressed_o disagrees with captured word");

endmodule

// File: tb.f
+incdir+.
cdec_pkg.sv
cdec_quad0.sv
cdec_quad1.sv
cdec_quad2.sv
cdec_expander.sv
cdec_top.sv
tb_cdec.sv

// File: tb_cdec_ref.svh
/*
 * testbench reference model for the compressed expander
 * expected RV32 form of a fetch word, xorshift generator and compare task
 */

// RV32 major opcodes
localparam logic [6:0] op_load     = 7'h03;
localparam logic [6:0] op_load_fp  = 7'h07;
localparam logic [6:0] op_opimm    = 7'h13;
localparam logic [6:0] op_store    = 7'h23;
localparam logic [6:0] op_store_fp = 7'h27;
localparam logic [6:0] op_op       = 7'h33;
localparam logic [6:0] op_lui      = 7'h37;
localparam logic [6:0] op_branch   = 7'h63;
localparam logic [6:0] op_jalr     = 7'h67;
localparam logic [6:0] op_jal      = 7'h6f;

////////////////////////////////////////////////////////////////////////////
// RV32 format builders
////////////////////////////////////////////////////////////////////////////

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [6:0] op);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] op);
  return {f7, rs2, rs1, f3, rd, op};
endfunction

// imm bit 0 is dropped
function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [6:0] op);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
endfunction

// returns {illegal, compressed, expansion}
function automatic logic [33:0] exp_ref(input logic [31:0] w);
  logic [15:0] c;
  logic [31:0] r;
  logic        ill;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [4:0]  rdp;
  logic [4:0]  rs1p;
  logic [11:0] imm6;
  logic [6:0]  uw;
  logic [7:0]  ul;
  logic [7:0]  us;
  logic [9:0]  nz;
  logic [11:0] jo;
  logic [8:0]  bo;
  begin
    c    = w[15:0];
    r    = 32'h0;
    ill  = 1'b0;
    rd   = c[11:7];
    rs2  = c[6:2];
    rdp  = {2'b01, c[4:2]};
    rs1p = {2'b01, c[9:7]};
    imm6 = {{7{c[12]}}, c[6:2]};
    // offsets reassembled from the scattered immediate fields
    uw   = {c[5], c[12:10], c[6], 2'b00};
    ul   = {c[3:2], c[12], c[6:4], 2'b00};
    us   = {c[8:7], c[12:9], 2'b00};
    nz   = {c[10:7], c[12:11], c[5], c[6], 2'b00};
    jo   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    bo   = {c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    case ({c[1:0], c[15:13]})
      5'b00_000: begin
        r   = enc_i({2'b00, nz}, 5'd2, 3'b000, rdp, op_opimm);
        ill = (nz == 10'd0);
      end
      5'b00_010, 5'b00_011:
        r = enc_i({5'd0, uw}, rs1p, 3'b010, rdp, c[13] ? op_load_fp : op_load);
      5'b00_110, 5'b00_111:
        r = enc_s({5'd0, uw}, rdp, rs1p, 3'b010, c[13] ? op_store_fp : op_store);
      5'b01_000: r = enc_i(imm6, rd, 3'b000, rd, op_opimm);
      5'b01_001, 5'b01_101: r = enc_j({{9{c[12]}}, jo}, c[15] ? 5'd0 : 5'd1, op_jal);
      5'b01_010: r = enc_i(imm6, 5'd0, 3'b000, rd, op_opimm);
      5'b01_011: begin
        ill = ({c[12], c[6:2]} == 6'd0);
        if (rd == 5'd2) begin
          r = enc_i({{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'h0}, 5'd2, 3'b000, 5'd2,
                    op_opimm);
        end else begin
          r = {{15{c[12]}}, c[6:2], rd, op_lui};
        end
      end
      5'b01_100: begin
        case (c[11:10])
          2'b00, 2'b01: begin
            r   = enc_i({1'b0, c[10], 4'h0, c[12], c[6:2]}, rs1p, 3'b101, rs1p, op_opimm);
            ill = c[12];
          end
          2'b10: r = enc_i(imm6, rs1p, 3'b111, rs1p, op_opimm);
          default: begin
            ill = c[12];
            case (c[6:5])
              2'b00: r = enc_r(7'h20, rdp, rs1p, 3'b000, rs1p, op_op);
              2'b01: r = enc_r(7'h00, rdp, rs1p, 3'b100, rs1p, op_op);
              2'b10: r = enc_r(7'h00, rdp, rs1p, 3'b110, rs1p, op_op);
              default: r = enc_r(7'h00, rdp, rs1p, 3'b111, rs1p, op_op);
            endcase
          end
        endcase
      end
      5'b01_110, 5'b01_111:
        r = enc_b({{4{c[12]}}, bo}, 5'd0, rs1p, {2'b00, c[13]}, op_branch);
      5'b10_000: begin
        r   = enc_i({6'd0, c[12], c[6:2]}, rd, 3'b001, rd, op_opimm);
        ill = c[12];
      end
      5'b10_010, 5'b10_011: begin
        r   = enc_i({4'h0, ul}, 5'd2, 3'b010, rd, c[13] ? op_load_fp : op_load);
        // flwsp may target f0
        ill = !c[13] && (rd == 5'd0);
      end
      5'b10_100: begin
        if (!c[12] && (rs2 == 5'd0)) begin
          r   = enc_i(12'd0, rd, 3'b000, 5'd0, op_jalr);
          ill = (rd == 5'd0);
        end else if (!c[12]) begin
          r = enc_r(7'h00, rs2, 5'd0, 3'b000, rd, op_op);
        end else if ((rs2 == 5'd0) && (rd == 5'd0)) begin
          r = 32'h0010_0073;
        end else if (rs2 == 5'd0) begin
          r = enc_i(12'd0, rd, 3'b000, 5'd1, op_jalr);
        end else begin
          r = enc_r(7'h00, rs2, rd, 3'b000, rd, op_op);
        end
      end
      5'b10_110, 5'b10_111:
        r = enc_s({4'h0, us}, rs2, 5'd2, 3'b010, c[13] ? op_store_fp : op_store);
      // reserved code, double forms, and full words handled below
      default: ill = 1'b1;
    endcase
    if (w[1:0] == 2'b11) begin
      exp_ref = {2'b00, w};
    end else begin
      exp_ref = {ill, 1'b1, r};
    end
  end
endfunction

// 32-bit xorshift, shifts 13/17/5
function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] x;
  begin
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  end
endfunction

task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
  if (exp !== act) begin
    $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    err_cnt++;
  end
endtask

// File: tb_cdec.sv
/*
 * testbench for the compressed expander stage
 * directed and random fetch words checked against a reference model
 */

`timescale 1ns/10ps

module tb_cdec;

  // about 1200 strobes plus gaps run near 3000 cycles, limit with margin
  localparam int max_cycles = 5000;
  localparam int stream_len = 1000;

  logic        clk = 1'b0;
  logic        rst_n_i;
  logic        valid_i;
  logic [31:0] instr_i;
  logic        valid_o;
  logic [31:0] instr_o;
  logic        is_compressed_o;
  logic        illegal_o;

  int          err_cnt;
  int          test_cnt;
  int          fail_cnt;
  int          cyc;
  logic [31:0] rng;
  // valid_i seen at the last edge, valid_o must follow it
  logic        strobe_d;
  // expected results and test names in strobe order
  logic [33:0] exp_q[$];
  string       name_q[$];

  `include "tb_cdec_ref.svh"

  cdec_top #(
    .FPU(1)
  ) dut_i (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .valid_i         (valid_i),
    .instr_i         (instr_i),
    .valid_o         (valid_o),
    .instr_o         (instr_o),
    .is_compressed_o (is_compressed_o),
    .illegal_o       (illegal_o)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cyc++;
    if (cyc >= max_cycles) begin
      $display("timeout after %0d cycles, %0d words still pending", cyc, exp_q.size());
      $display("Testbench failed");
      $finish;
    end
  end

  always @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      strobe_d <= 1'b0;
    end else begin
      strobe_d <= valid_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // scoreboard, outputs sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : compare_proc
    logic [33:0] e;
    string       n;
    if (!rst_n_i) begin
      check_val("reset valid_o", 32'd0, valid_o);
      check_val("reset illegal_o", 32'd0, illegal_o);
      check_val("reset is_compressed_o", 32'd0, is_compressed_o);
      check_val("reset instr_o", 32'd0, instr_o);
    end else begin
      check_val("valid timing", strobe_d, valid_o);
      if (valid_o) begin
        if (exp_q.size() == 0) begin
          $display("valid_o went high with no word pending");
          err_cnt++;
        end else begin
          e = exp_q.pop_front();
          n = name_q.pop_front();
          check_val({n, " compressed"}, e[32], is_compressed_o);
          check_val({n, " illegal"}, e[33], illegal_o);
          // expansion of an illegal word is undefined
          if (!e[33]) begin
            check_val({n, " instr"}, e[31:0], instr_o);
          end
        end
      end
    end
  end

  task automatic next_rand(output logic [31:0] v);
    rng = xorshift(rng);
    v   = rng;
  endtask

  // one strobe, returns 1 ns after the capturing edge
  task automatic send(input logic [31:0] w, input string name);
    exp_q.push_back(exp_ref(w));
    name_q.push_back(name);
    valid_i = 1'b1;
    instr_i = w;
    @(posedge clk);
    #1;
    valid_i = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // four words with fixed opcode bits, the rest random
  task automatic send_pattern(input logic [15:0] mask, input logic [15:0] val,
                              input string name, input bit legal);
    logic [31:0] w;
    logic [33:0] e;
    repeat (4) begin
      next_rand(w);
      w[15:0] = (w[15:0] & ~mask) | val;
      e = exp_ref(w);
      // reroll until the random fields form a legal word
      while (legal && e[33]) begin
        next_rand(w);
        w[15:0] = (w[15:0] & ~mask) | val;
        e = exp_ref(w);
      end
      send(w, name);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    #1;
    test_cnt++;
    if (err_cnt != err_before) begin
      fail_cnt++;
    end
    $display("test %-14s done, %0d errors", name, err_cnt - err_before);
  endtask

  initial begin : main_proc
    logic [31:0] w;
    logic [31:0] g;
    int          e0;
    rst_n_i = 1'b1;
    valid_i = 1'b0;
    instr_i = 32'h0;
    rng     = 32'h67b9;

    // reset and strobe timing
    e0 = err_cnt;
    #1;
    rst_n_i = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    // an edge with valid_i low must leave the reset values in place
    @(posedge clk);
    @(negedge clk);
    check_val("post-reset valid_o", 32'd0, valid_o);
    check_val("post-reset illegal_o", 32'd0, illegal_o);
    check_val("post-reset is_compressed_o", 32'd0, is_compressed_o);
    @(posedge clk);
    #1;
    next_rand(w);
    send(w, "reset");
    idle(2);
    next_rand(w);
    send(w, "reset");
    end_test("reset", e0);

    // 32-bit words pass through
    e0 = err_cnt;
    repeat (50) begin
      next_rand(w);
      w[1:0] = 2'b11;
      send(w, "passthrough");
    end
    end_test("passthrough", e0);

    // every kept integer instruction, hints included
    e0 = err_cnt;
    send_pattern(16'he003, 16'h0000, "c.addi4spn", 1'b1);
    send_pattern(16'he003, 16'h4000, "c.lw", 1'b1);
    send_pattern(16'he003, 16'hc000, "c.sw", 1'b1);
    send_pattern(16'he003, 16'h0001, "c.addi", 1'b1);
    send_pattern(16'hef83, 16'h0001, "c.nop hint", 1'b1);
    send_pattern(16'he003, 16'h2001, "c.jal", 1'b1);
    send_pattern(16'he003, 16'h4001, "c.li", 1'b1);
    send_pattern(16'hef83, 16'h4001, "c.li hint", 1'b1);
    send_pattern(16'he803, 16'h6801, "c.lui", 1'b1);
    send_pattern(16'hef83, 16'h6101, "c.addi16sp", 1'b1);
    send_pattern(16'hec03, 16'h8001, "c.srli", 1'b1);
    send_pattern(16'hec03, 16'h8401, "c.srai", 1'b1);
    send_pattern(16'hec03, 16'h8801, "c.andi", 1'b1);
    send_pattern(16'hfc63, 16'h8c01, "c.sub", 1'b1);
    send_pattern(16'hfc63, 16'h8c21, "c.xor", 1'b1);
    send_pattern(16'hfc63, 16'h8c41, "c.or", 1'b1);
    send_pattern(16'hfc63, 16'h8c61, "c.and", 1'b1);
    send_pattern(16'he003, 16'ha001, "c.j", 1'b1);
    send_pattern(16'he003, 16'hc001, "c.beqz", 1'b1);
    send_pattern(16'he003, 16'he001, "c.bnez", 1'b1);
    send_pattern(16'he003, 16'h0002, "c.slli", 1'b1);
    send_pattern(16'he003, 16'h4002, "c.lwsp", 1'b1);
    send_pattern(16'he003, 16'hc002, "c.swsp", 1'b1);
    send_pattern(16'hf07f, 16'h8002, "c.jr", 1'b1);
    send_pattern(16'hf043, 16'h8042, "c.mv", 1'b1);
    send_pattern(16'hffc3, 16'h8042, "c.mv hint", 1'b1);
    send_pattern(16'hf87f, 16'h9802, "c.jalr", 1'b1);
    send_pattern(16'hffff, 16'h9002, "c.ebreak", 1'b1);
    send_pattern(16'hf043, 16'h9042, "c.add", 1'b1);
    end_test("directed", e0);

    // float word forms, then reserved and dropped encodings
    e0 = err_cnt;
    send_pattern(16'he003, 16'h6000, "c.flw", 1'b1);
    send_pattern(16'he003, 16'he000, "c.fsw", 1'b1);
    send_pattern(16'he003, 16'h6002, "c.flwsp", 1'b1);
    send_pattern(16'he003, 16'he002, "c.fswsp", 1'b1);
    send_pattern(16'hffff, 16'h0000, "all-zero", 1'b0);
    send_pattern(16'hffe3, 16'h0000, "addi4spn zero", 1'b0);
    send_pattern(16'hf07f, 16'h6001, "lui zero", 1'b0);
    send_pattern(16'hffff, 16'h6101, "addi16sp zero", 1'b0);
    send_pattern(16'hef83, 16'h4002, "lwsp x0", 1'b0);
    send_pattern(16'hffff, 16'h8002, "jr x0", 1'b0);
    send_pattern(16'hfc03, 16'h9001, "srli bit12", 1'b0);
    send_pattern(16'hfc03, 16'h9401, "srai bit12", 1'b0);
    send_pattern(16'hf003, 16'h1002, "slli bit12", 1'b0);
    send_pattern(16'hfc03, 16'h9c01, "subw/addw", 1'b0);
    send_pattern(16'he003, 16'h8000, "q0 reserved", 1'b0);
    send_pattern(16'he003, 16'h2000, "c.fld", 1'b0);
    send_pattern(16'he003, 16'ha000, "c.fsd", 1'b0);
    send_pattern(16'he003, 16'h2002, "c.fldsp", 1'b0);
    send_pattern(16'he003, 16'ha002, "c.fsdsp", 1'b0);
    end_test("float_illegal", e0);

    // random words, a zero gap gives back-to-back strobes
    e0 = err_cnt;
    for (int i = 0; i < stream_len; i++) begin
      next_rand(w);
      send(w, "random");
      next_rand(g);
      idle(g % 4);
    end
    end_test("random", e0);

    $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
